// ==== hdl/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width
`define RV_XLEN         32

// First fetch address out of reset
`define RV_RESET_PC     32'h0000_0000

// ------------------------------------------------------------
// Major opcodes, instr[6:0]
// ------------------------------------------------------------
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011

// ------------------------------------------------------------
// ALU operations
// ------------------------------------------------------------
`define RV_ALU_ADD      4'd0
`define RV_ALU_SUB      4'd1
`define RV_ALU_SLL      4'd2
`define RV_ALU_SLT      4'd3
`define RV_ALU_SLTU     4'd4
`define RV_ALU_XOR      4'd5
`define RV_ALU_SRL      4'd6
`define RV_ALU_SRA      4'd7
`define RV_ALU_OR       4'd8
`define RV_ALU_AND      4'd9
`define RV_ALU_NE       4'd10

// First ALU operand select
`define RV_SRC1_REG     2'd0
`define RV_SRC1_PC      2'd1
`define RV_SRC1_ZERO    2'd2

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // Data or address word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // ALU operation code
    typedef logic [3:0] alu_op_t;

    // Instruction sequencer states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_e;

    // Decoded control, one instruction at a time
    typedef struct packed {
        logic       reg_wen;
        logic       mem_wen;
        logic       mem_ren;
        logic       jump;
        // Set for JALR only
        logic       jump_reg;
        logic       branch;
        // BEQ, BGE, BGEU take the branch on a false compare
        logic       branch_inv;
        alu_op_t    alu_op;
        logic [1:0] src1_sel;
        logic       src2_imm;
        word_t      imm;
    } ctrl_t;

    // Master side of the Wishbone bus
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat_w;
        logic [3:0] sel;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic       ack;
        word_t      dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/rv_control.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_control (
    input  rv_pkg::word_t instr,
    output rv_pkg::ctrl_t ctrl
);

    import rv_pkg::*;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Immediates of each format, sign extended
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------
    always_comb begin
        // Unknown opcodes decode to a no-op
        ctrl          = '0;
        ctrl.alu_op   = `RV_ALU_ADD;
        ctrl.src1_sel = `RV_SRC1_REG;
        ctrl.imm      = imm_i;
        case (opcode)
            `RV_OP_LUI: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.src1_sel = `RV_SRC1_ZERO;
                ctrl.src2_imm = 1'b1;
                ctrl.imm      = imm_u;
            end
            `RV_OP_AUIPC: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.src1_sel = `RV_SRC1_PC;
                ctrl.src2_imm = 1'b1;
                ctrl.imm      = imm_u;
            end
            `RV_OP_JAL: begin
                // ALU forms pc + offset, link written from pc + 4
                ctrl.reg_wen  = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.src1_sel = `RV_SRC1_PC;
                ctrl.src2_imm = 1'b1;
                ctrl.imm      = imm_j;
            end
            `RV_OP_JALR: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.jump_reg = 1'b1;
                ctrl.src2_imm = 1'b1;
            end
            `RV_OP_BRANCH: begin
                // Compare rs1 with rs2, offset goes out on imm
                ctrl.branch = 1'b1;
                ctrl.imm    = imm_b;
                case (funct3)
                    3'b000: begin
                        ctrl.alu_op     = `RV_ALU_NE;
                        ctrl.branch_inv = 1'b1;
                    end
                    3'b001: ctrl.alu_op = `RV_ALU_NE;
                    3'b100: ctrl.alu_op = `RV_ALU_SLT;
                    3'b101: begin
                        ctrl.alu_op     = `RV_ALU_SLT;
                        ctrl.branch_inv = 1'b1;
                    end
                    3'b110: ctrl.alu_op = `RV_ALU_SLTU;
                    3'b111: begin
                        ctrl.alu_op     = `RV_ALU_SLTU;
                        ctrl.branch_inv = 1'b1;
                    end
                    // Reserved funct3 never taken
                    default: ctrl.branch = 1'b0;
                endcase
            end
            `RV_OP_LOAD: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.mem_ren  = 1'b1;
                ctrl.src2_imm = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.mem_wen  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.imm      = imm_s;
            end
            `RV_OP_IMM, `RV_OP_REG: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.src2_imm = (opcode == `RV_OP_IMM);
                case (funct3)
                    // SUB only exists in the register form
                    3'b000: ctrl.alu_op = (opcode == `RV_OP_REG && funct7[5]) ?
                                          `RV_ALU_SUB : `RV_ALU_ADD;
                    3'b001: ctrl.alu_op = `RV_ALU_SLL;
                    3'b010: ctrl.alu_op = `RV_ALU_SLT;
                    3'b011: ctrl.alu_op = `RV_ALU_SLTU;
                    3'b100: ctrl.alu_op = `RV_ALU_XOR;
                    3'b101: ctrl.alu_op = funct7[5] ? `RV_ALU_SRA : `RV_ALU_SRL;
                    3'b110: ctrl.alu_op = `RV_ALU_OR;
                    default: ctrl.alu_op = `RV_ALU_AND;
                endcase
            end
            default: ;
        endcase

        // One bus direction per instruction
        assert (!(ctrl.mem_wen && ctrl.mem_ren));
    end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);

    import rv_pkg::*;

    // Shift amount, low five bits only
    logic [4:0] shamt;

    // Compare flags
    logic lt_s;
    logic lt_u;
    logic ne;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign ne    = a != b;

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin
        case (op)
            `RV_ALU_ADD:  result = a + b;
            `RV_ALU_SUB:  result = a - b;
            `RV_ALU_SLL:  result = a << shamt;
            `RV_ALU_SRL:  result = a >> shamt;
            // Arithmetic shift keeps the sign
            `RV_ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            `RV_ALU_XOR:  result = a ^ b;
            `RV_ALU_OR:   result = a | b;
            `RV_ALU_AND:  result = a & b;
            // Compares return 0 or 1 in bit 0
            `RV_ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            `RV_ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            `RV_ALU_NE:   result = {{(`RV_XLEN-1){1'b0}}, ne};
            default:      result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire                clk,
    input  wire                reset,
    input  rv_pkg::reg_addr_t  rs1_addr,
    input  rv_pkg::reg_addr_t  rs2_addr,
    output rv_pkg::word_t      rs1_data,
    output rv_pkg::word_t      rs2_data,
    input  wire                wen,
    input  rv_pkg::reg_addr_t  rd_addr,
    input  rv_pkg::word_t      rd_data
);

    import rv_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs [1:31];

    // Write port, x0 writes dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Asynchronous read ports
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/rv_pc_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_pc_counter (
    input  wire           clk,
    input  wire           reset,
    input  wire           step,
    input  wire           load,
    input  rv_pkg::word_t target,
    output rv_pkg::word_t pc
);

    import rv_pkg::*;

    word_t pc_q;

    // Load wins, step is the sequential path
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RV_RESET_PC;
        end else if (load) begin
            pc_q <= target;
        end else if (step) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc = pc_q;

    // Sequencer asks for one update at a time
    assert property (@(posedge clk) disable iff (reset) !(step && load));

    // Fetch addresses stay on word boundaries
    assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/rv_core_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_fsm (
    input  wire             clk,
    input  wire             reset,
    output rv_pkg::wb_req_t wb_req,
    input  rv_pkg::wb_rsp_t wb_rsp,
    output rv_pkg::word_t   instr,
    input  rv_pkg::ctrl_t   ctrl,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   alu_result,
    input  rv_pkg::word_t   rs2_data,
    output logic            reg_wen,
    output rv_pkg::word_t   rd_data,
    output logic            pc_step,
    output logic            pc_load,
    output rv_pkg::word_t   pc_target
);

    import rv_pkg::*;

    core_state_e state_q;

    // Bus master registers
    logic  bus_cyc_q;
    logic  bus_we_q;
    word_t bus_adr_q;
    word_t bus_dat_q;

    // Instruction, load data and next PC decision
    word_t instr_q;
    word_t load_q;
    logic  take_q;
    word_t target_q;

    word_t pc_plus4;
    word_t next_pc;
    word_t jump_target;
    logic  branch_hit;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = take_q ? target_q : pc_plus4;

    // Compare in bit 0 is flipped for BEQ, BGE and BGEU
    assign branch_hit = alu_result[0] ^ ctrl.branch_inv;

    // Branch target from a side adder while the ALU holds the compare
    always_comb begin
        if (ctrl.jump_reg) begin
            jump_target = {alu_result[31:1], 1'b0};
        end else if (ctrl.jump) begin
            jump_target = alu_result;
        end else begin
            jump_target = pc + ctrl.imm;
        end
    end

    // ------------------------------------------------------------
    // Sequencer and bus handshake
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= FETCH;
            bus_cyc_q <= 1'b0;
            bus_we_q  <= 1'b0;
            instr_q   <= '0;
            take_q    <= 1'b0;
        end else begin
            case (state_q)
                FETCH: begin
                    if (!bus_cyc_q) begin
                        // First fetch after reset as WRITEBACK opens the later ones
                        bus_cyc_q <= 1'b1;
                        bus_we_q  <= 1'b0;
                    end else if (wb_rsp.ack) begin
                        instr_q   <= wb_rsp.dat_r;
                        bus_cyc_q <= 1'b0;
                        state_q   <= DECODE;
                    end
                end
                DECODE: begin
                    state_q <= EXECUTE;
                end
                EXECUTE: begin
                    take_q <= ctrl.jump || (ctrl.branch && branch_hit);
                    if (ctrl.mem_ren || ctrl.mem_wen) begin
                        bus_cyc_q <= 1'b1;
                        bus_we_q  <= ctrl.mem_wen;
                        state_q   <= MEMORY;
                    end else begin
                        state_q <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (wb_rsp.ack) begin
                        bus_cyc_q <= 1'b0;
                        bus_we_q  <= 1'b0;
                        state_q   <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    // Next fetch goes out with the PC update
                    bus_cyc_q <= 1'b1;
                    bus_we_q  <= 1'b0;
                    state_q   <= FETCH;
                end
                default: begin
                    state_q <= FETCH;
                end
            endcase
        end
    end

    // Address, store data and captured words
    always_ff @(posedge clk) begin
        case (state_q)
            FETCH: begin
                if (!bus_cyc_q) begin
                    bus_adr_q <= pc;
                end
            end
            EXECUTE: begin
                bus_adr_q <= alu_result;
                bus_dat_q <= rs2_data;
                target_q  <= jump_target;
            end
            MEMORY: begin
                if (wb_rsp.ack) begin
                    load_q <= wb_rsp.dat_r;
                end
            end
            WRITEBACK: begin
                bus_adr_q <= next_pc;
            end
            default: ;
        endcase
    end

    // stb follows cyc on word-wide accesses
    always_comb begin
        wb_req.cyc   = bus_cyc_q;
        wb_req.stb   = bus_cyc_q;
        wb_req.we    = bus_we_q;
        wb_req.adr   = bus_adr_q;
        wb_req.dat_w = bus_dat_q;
        wb_req.sel   = 4'hf;
    end

    assign instr = instr_q;

    // Writeback and PC update
    assign reg_wen   = (state_q == WRITEBACK) && ctrl.reg_wen;
    assign pc_load   = (state_q == WRITEBACK) && take_q;
    assign pc_step   = (state_q == WRITEBACK) && !take_q;
    assign pc_target = target_q;

    // Link for jumps, load word, else ALU
    always_comb begin
        if (ctrl.jump) begin
            rd_data = pc_plus4;
        end else if (ctrl.mem_ren) begin
            rd_data = load_q;
        end else begin
            rd_data = alu_result;
        end
    end

    // Strobe never rises outside a bus cycle
    assert property (@(posedge clk) disable iff (reset) $rose(wb_req.stb) |-> wb_req.cyc);

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_top (
    input  wire             clk,
    input  wire             reset,
    output rv_pkg::wb_req_t wb_req,
    input  rv_pkg::wb_rsp_t wb_rsp
);

    import rv_pkg::*;

    word_t instr;
    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t pc;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  reg_wen;
    word_t rd_data;
    logic  pc_step;
    logic  pc_load;
    word_t pc_target;

    // ------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.src1_sel)
            `RV_SRC1_PC:   alu_a = pc;
            `RV_SRC1_ZERO: alu_a = '0;
            default:       alu_a = rs1_data;
        endcase
    end

    assign alu_b = ctrl.src2_imm ? ctrl.imm : rs2_data;

    rv_core_fsm fsm0 (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .instr      (instr),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .reg_wen    (reg_wen),
        .rd_data    (rd_data),
        .pc_step    (pc_step),
        .pc_load    (pc_load),
        .pc_target  (pc_target)
    );

    rv_control control0 (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Register indices straight from the held instruction
    rv_regfile regfile0 (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (reg_wen),
        .rd_addr  (instr[11:7]),
        .rd_data  (rd_data)
    );

    rv_alu alu0 (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    rv_pc_counter pc0 (
        .clk    (clk),
        .reset  (reset),
        .step   (pc_step),
        .load   (pc_load),
        .target (pc_target),
        .pc     (pc)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Power-on reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/rv_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_checker (
    input  wire               clk,
    input  wire               reset,
    input  rv_pkg::wb_req_t   wb_req,
    input  rv_pkg::wb_rsp_t   wb_rsp,
    input  rv_pkg::word_t     expected,
    input  wire [8*16-1:0]    test_name,
    output int                result_count,
    output int                pass_count,
    output int                fail_count
);

    import rv_pkg::*;

    localparam word_t RESULT_ADR  = 32'h0000_0100;
    localparam word_t SCRATCH_ADR = 32'h0000_0080;

    initial begin
        result_count = 0;
        pass_count   = 0;
        fail_count   = 0;
    end

    // ------------------------------------------------------------
    // Acknowledged bus cycles sampled on the rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset && wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
            // Every access is a full word
            if (wb_req.sel !== 4'hf) begin
                $display("ERROR t=%0t wb_req.sel expected %h actual %h (%0s)",
                         $time, 4'hf, wb_req.sel, test_name);
                fail_count++;
            end
            // Word-aligned addresses only
            if (wb_req.adr[1:0] != 2'b00) begin
                $display("FAIL %0s accessed misaligned address %h at time %0t",
                         test_name, wb_req.adr, $time);
                fail_count++;
            end
            if (wb_req.we) begin
                if (wb_req.adr == RESULT_ADR) begin
                    if (wb_req.dat_w === expected) begin
                        $display("PASS %0s result %h", test_name, wb_req.dat_w);
                        pass_count++;
                    end else begin
                        $display("ERROR t=%0t wb_req.dat_w expected %h actual %h (%0s)",
                                 $time, expected, wb_req.dat_w, test_name);
                        fail_count++;
                    end
                    result_count++;
                end else if (wb_req.adr != SCRATCH_ADR) begin
                    // Only the result word and the scratch word are legal targets
                    $display("FAIL %0s wrote to unexpected address %h at time %0t",
                             test_name, wb_req.adr, $time);
                    fail_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/rv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_tb;

    import rv_pkg::*;

    localparam int NT        = 8;
    localparam int MAX_WORDS = 12;
    localparam int PERIOD    = 4;

    // Major opcodes as the ISA encodes them
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;

    logic      clk;
    logic      por_reset;
    logic      test_reset;
    logic      core_reset;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    word_t     cur_expected;
    logic [8*16-1:0] cur_name;
    int        result_count;
    int        pass_count;
    int        fail_count;

    // Program table
    word_t           prog [NT][MAX_WORDS];
    int              plen [NT];
    word_t           expected [NT];
    logic [8*16-1:0] names [NT];
    logic            table_ready;

    // Memory model state
    word_t mem [0:255];
    logic  pending;
    int    wait_left;

    assign core_reset = por_reset | test_reset;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) clock0 (
        .clk   (clk),
        .reset (por_reset)
    );

    rv_core_top dut0 (
        .clk    (clk),
        .reset  (core_reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    rv_checker checker0 (
        .clk          (clk),
        .reset        (core_reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .expected     (cur_expected),
        .test_name    (cur_name),
        .result_count (result_count),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    // ------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------
    function automatic word_t i_type(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] op);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_REG};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input int rd, input logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input logic [11:0] imm);
        return i_type(imm, rs1, 3'b000, rd, OPC_IMM);
    endfunction

    task automatic append_word(input int t, input word_t w);
        prog[t][plen[t]] = w;
        plen[t]++;
    endtask

    // Result store and the closing self loop
    task automatic finish_program(input int t, input int rs);
        append_word(t, s_type(12'h100, rs, 0));
        append_word(t, j_type(21'd0, 0));
    endtask

    // A branch guarding one counter increment
    task automatic add_guarded_branch(input int t, input logic [2:0] f3, input int rs1,
                                      input int rs2);
        append_word(t, b_type(f3, rs1, rs2, 13'd8));
        append_word(t, addi(3, 3, 12'd1));
    endtask

    task automatic build_table();
        for (int t = 0; t < NT; t++) begin
            plen[t] = 0;
        end
        // Add and subtract with wraparound
        names[0] = "add_sub";
        append_word(0, addi(1, 0, 12'hfff));
        append_word(0, addi(2, 1, 12'd2));
        append_word(0, addi(3, 0, 12'd100));
        append_word(0, r_type(7'h20, 3, 2, 3'b000, 4));
        append_word(0, r_type(7'h00, 1, 4, 3'b000, 5));
        finish_program(0, 5);
        expected[0] = 32'hffff_ff9c;
        // Logic ops and shifts with SRA on a negative value
        names[1] = "logic_shift";
        append_word(1, addi(1, 0, 12'hff0));
        append_word(1, i_type(12'h402, 1, 3'b101, 2, OPC_IMM));
        append_word(1, i_type(12'd28, 1, 3'b101, 3, OPC_IMM));
        append_word(1, i_type(12'd8, 3, 3'b001, 4, OPC_IMM));
        append_word(1, r_type(7'h00, 4, 2, 3'b100, 5));
        append_word(1, r_type(7'h00, 3, 5, 3'b110, 6));
        append_word(1, r_type(7'h00, 1, 6, 3'b111, 7));
        finish_program(1, 7);
        expected[1] = 32'hffff_f0f0;
        // Signed and unsigned compares packed into bits
        names[2] = "slt_sltu";
        append_word(2, addi(1, 0, 12'hfff));
        append_word(2, addi(2, 0, 12'd1));
        append_word(2, r_type(7'h00, 2, 1, 3'b010, 3));
        append_word(2, r_type(7'h00, 2, 1, 3'b011, 4));
        append_word(2, r_type(7'h00, 1, 2, 3'b011, 5));
        append_word(2, i_type(12'd1, 4, 3'b001, 4, OPC_IMM));
        append_word(2, i_type(12'd2, 5, 3'b001, 5, OPC_IMM));
        append_word(2, r_type(7'h00, 4, 3, 3'b110, 3));
        append_word(2, r_type(7'h00, 5, 3, 3'b110, 3));
        finish_program(2, 3);
        expected[2] = 32'h0000_0005;
        // Branches on x1 = -1 and x2 = 1
        names[3] = "branch_a";
        names[4] = "branch_b";
        names[5] = "branch_c";
        for (int t = 3; t < 6; t++) begin
            append_word(t, addi(1, 0, 12'hfff));
            append_word(t, addi(2, 0, 12'd1));
        end
        add_guarded_branch(3, 3'b000, 1, 2);
        add_guarded_branch(3, 3'b001, 1, 1);
        add_guarded_branch(3, 3'b100, 1, 2);
        add_guarded_branch(3, 3'b101, 1, 2);
        expected[3] = 32'd3;
        add_guarded_branch(4, 3'b110, 1, 2);
        add_guarded_branch(4, 3'b111, 1, 2);
        add_guarded_branch(4, 3'b000, 1, 1);
        add_guarded_branch(4, 3'b001, 1, 2);
        expected[4] = 32'd1;
        add_guarded_branch(5, 3'b100, 2, 1);
        add_guarded_branch(5, 3'b101, 2, 1);
        add_guarded_branch(5, 3'b110, 2, 1);
        add_guarded_branch(5, 3'b111, 2, 1);
        expected[5] = 32'd2;
        for (int t = 3; t < 6; t++) begin
            finish_program(t, 3);
        end
        // Links from JAL at 0 and JALR at 12 with odd target 25 landing on 24
        names[6] = "jal_jalr";
        append_word(6, j_type(21'd8, 1));
        append_word(6, j_type(21'd0, 0));
        append_word(6, addi(2, 0, 12'd25));
        append_word(6, i_type(12'd0, 2, 3'b000, 3, OPC_JALR));
        append_word(6, j_type(21'd0, 0));
        append_word(6, j_type(21'd0, 0));
        append_word(6, i_type(12'd8, 3, 3'b001, 4, OPC_IMM));
        append_word(6, r_type(7'h00, 1, 4, 3'b110, 4));
        finish_program(6, 4);
        expected[6] = 32'h0000_1004;
        // Upper immediates and a memory round trip through 0x80
        names[7] = "lui_auipc_mem";
        append_word(7, u_type(20'h12345, 1, OPC_LUI));
        append_word(7, addi(1, 1, 12'h678));
        append_word(7, u_type(20'h00001, 2, OPC_AUIPC));
        append_word(7, r_type(7'h00, 2, 1, 3'b000, 3));
        append_word(7, s_type(12'h080, 3, 0));
        append_word(7, i_type(12'h080, 0, 3'b010, 4, OPC_LOAD));
        finish_program(7, 4);
        expected[7] = 32'h1234_6680;
    endtask

    // ------------------------------------------------------------
    // Wishbone slave memory with random wait states
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (core_reset) begin
            wb_rsp.ack = 1'b0;
            pending    = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                if (wb_req.we) begin
                    mem[wb_req.adr[9:2]] = wb_req.dat_w;
                end
                wb_rsp.dat_r = mem[wb_req.adr[9:2]];
                wb_rsp.ack   = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    // ------------------------------------------------------------
    // Test loop
    // ------------------------------------------------------------
    initial begin
        int seen;
        void'($urandom(32'h9f7));
        wb_rsp       = '0;
        test_reset   = 1'b1;
        pending      = 1'b0;
        wait_left    = 0;
        cur_expected = '0;
        cur_name     = "none";
        table_ready  = 1'b0;
        build_table();
        table_ready  = 1'b1;
        wait (!por_reset);
        for (int t = 0; t < NT; t++) begin
            @(negedge clk);
            test_reset = 1'b1;
            for (int a = 0; a < 256; a++) begin
                mem[a] = '0;
            end
            for (int i = 0; i < plen[t]; i++) begin
                mem[i] = prog[t][i];
            end
            cur_expected = expected[t];
            cur_name     = names[t];
            seen         = result_count;
            repeat (3) @(negedge clk);
            test_reset = 1'b0;
            while (result_count == seen) begin
                @(negedge clk);
            end
        end
        repeat (2) @(negedge clk);
        $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == NT) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog allows 5 cycles per instruction with up to 4 wait states each
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = 2000;
        for (int t = 0; t < NT; t++) begin
            limit_ns += plen[t] * 5 * 4 * PERIOD + 10 * PERIOD;
        end
        #(limit_ns);
        $display("Watchdog expired after %0d ns without all result stores", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_control.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_pc_counter.sv
hdl/rv_core_fsm.sv
hdl/rv_core_top.sv
bench/tb_clock_gen.sv
bench/rv_checker.sv
bench/rv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := rv_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) hdl/rv_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
